// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP       := tb_wb_soc_top
RTL_TOP   := wb_soc_top
FILELIST  := wb_soc_top.f
BUILD     := obj_dir
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// ==== tests/tb_wb_soc_top.sv ====
`default_nettype none

module tb_wb_soc_top;
    timeunit 1ns;
    timeprecision 1ns;

    import soc_pkg::*;

    localparam int          WAIT_LIMIT = 16;               // cycles per handshake
    localparam logic [31:0] FIXED      = 32'h0f_f0_55_aa;  // entries 7..4

    logic        sys_clk = 1'b0;
    logic        rst;
    wb_req_t     mreq [N_MASTERS];
    wb_rsp_t     mrsp [N_MASTERS];
    logic [1:0]  btn;
    logic [7:0]  led;
    logic [7:0]  led8;
    logic [3:0]  led4;
    int          mismatches;
    int          failures;
    logic [31:0] lfsr;
    logic [31:0] led_model;    // led register as the writes so far leave it
    logic        last_master;  // master that held the bus last
    logic        aborted;

    always #20 sys_clk = ~sys_clk;

    wb_soc_top u_dut (
        .sys_clk (sys_clk),
        .rst     (rst),
        .m0_req  (mreq[0]),
        .m1_req  (mreq[1]),
        .m0_rsp  (mrsp[0]),
        .m1_rsp  (mrsp[1]),
        .btn     (btn),
        .led     (led),
        .led8    (led8),
        .led4    (led4)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    function automatic wb_req_t make_req(input logic we, input logic [31:0] adr,
                                         input logic [31:0] dat, input logic [3:0] sel);
        wb_req_t r;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = adr;
        r.dat = dat;
        r.sel = sel;
        return r;
    endfunction

    function automatic logic [7:0] expected_led8(input logic [3:0] idx);
        int i;
        i = int'(idx);
        if (i < 4) begin
            return ~led_model[8*i +: 8];
        end
        return ~FIXED[8*(i-4) +: 8];
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp_val);
        if (got !== exp_val) begin
            mismatches++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp_val);
        end
    endtask

    task automatic finish_run();
        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic idle_gap();
        int n;
        n = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            n = n * 2 + int'(lfsr[0]);
        end
        repeat (n) @(negedge sys_clk);
    endtask

    // called on a falling edge, returns on the falling edge that saw ack or err
    task automatic bus_access(input logic mi, input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel,
                              output logic ack, output logic err, output logic [31:0] rdat);
        int n;
        mreq[mi] = make_req(we, adr, dat, sel);
        ack = 1'b0;
        err = 1'b0;
        rdat = '0;
        n = 0;
        while (!ack && !err && n < WAIT_LIMIT) begin
            @(negedge sys_clk);
            ack = mrsp[mi].ack;
            err = mrsp[mi].err;
            rdat = mrsp[mi].dat;
            n++;
        end
        mreq[mi] = '0;
        last_master = mi;
        if (!ack && !err) begin
            failures++;
            $display("timeout: master %0d got no response for address %h", mi, adr);
            aborted = 1'b1;
        end
    endtask

    // both masters read at once on an idle bus, the one that did not hold it last wins
    task automatic contend_read(input logic [31:0] adr0, input logic [31:0] adr1,
                                input logic [31:0] exp0, input logic [31:0] exp1);
        logic [1:0]  done;
        logic        first;
        logic        other;
        logic [31:0] exp_dat [N_MASTERS];
        int          n;
        first = ~last_master;
        other = last_master;
        exp_dat[0] = exp0;
        exp_dat[1] = exp1;
        @(negedge sys_clk);  // previous owner lets go of the grant
        mreq[0] = make_req(1'b0, adr0, '0, 4'hf);
        mreq[1] = make_req(1'b0, adr1, '0, 4'hf);
        done = '0;
        n = 0;
        while (done != 2'b11 && n < 3 * WAIT_LIMIT) begin
            @(negedge sys_clk);
            n++;
            if (mrsp[0].err || mrsp[1].err) begin
                failures++;
                $display("err response during contention read at %0t ns", $time);
            end
            if (!done[first] && mrsp[other].ack) begin
                failures++;
                $display("m%0d got ack while m%0d was still waiting at %0t ns",
                         other, first, $time);
            end
            for (int i = 0; i < N_MASTERS; i++) begin
                if (!done[i] && mrsp[i].ack) begin
                    compare_value($sformatf("contention read m%0d", i), mrsp[i].dat,
                                  exp_dat[i]);
                    mreq[i] = '0;
                    done[i] = 1'b1;
                end
            end
        end
        last_master = other;
        if (done != 2'b11) begin
            failures++;
            $display("timeout: contention reads did not both complete");
            aborted = 1'b1;
        end
    endtask

    task automatic press_button(input logic bi, input logic [3:0] exp_idx);
        int n;
        btn[bi] = 1'b1;
        n = 0;
        while (led4 !== exp_idx && n < WAIT_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        btn[bi] = 1'b0;
        if (led4 !== exp_idx) begin
            failures++;
            $display("timeout: led4 never reached %0d after button %0d", exp_idx, bi);
            aborted = 1'b1;
        end else begin
            repeat (2) @(negedge sys_clk);
            compare_value("led4", 32'(led4), 32'(exp_idx));
            compare_value("led8", 32'(led8), 32'(expected_led8(exp_idx)));
        end
    endtask

    initial begin
        string       line;
        int          fd;
        int          cnt;
        int          lineno;
        byte         op;
        int          m;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic [31:0] exp_val;
        logic        ack;
        logic        err;
        logic [31:0] rdat;
        logic [31:0] c_adr [N_MASTERS];
        logic [31:0] c_exp [N_MASTERS];
        mismatches = 0;
        failures = 0;
        lineno = 0;
        lfsr = 32'h5fef_11aa;
        led_model = '0;
        last_master = 1'b1;  // m0 takes the first tie
        aborted = 1'b0;
        mreq[0] = '0;
        mreq[1] = '0;
        btn = '0;
        rst = 1'b1;
        repeat (4) @(negedge sys_clk);
        rst = 1'b0;
        @(negedge sys_clk);
        compare_value("m0 ack,err after reset", 32'({mrsp[0].ack, mrsp[0].err}), 32'd0);
        compare_value("m1 ack,err after reset", 32'({mrsp[1].ack, mrsp[1].err}), 32'd0);
        compare_value("led after reset", 32'(led), 32'h00);
        compare_value("led8 after reset", 32'(led8), 32'hff);
        compare_value("led4 after reset", 32'(led4), 32'h0);

        // first tie after reset, both read the led register
        contend_read(32'h2000_0000, 32'h2000_0004, led_model, led_model);

        fd = $fopen("tests/wb_soc_stimulus.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open the stimulus file");
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            cnt = $fgets(line, fd);
            lineno++;
            if (cnt == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%c %d %h %h %h %h", op, m, adr, dat, sel, exp_val);
            if (cnt != 6) begin
                failures++;
                $display("stimulus line %0d could not be parsed", lineno);
                continue;
            end
            idle_gap();
            case (op)
                "W", "E": begin
                    bus_access(m[0], 1'b1, adr, dat, sel, ack, err, rdat);
                    compare_value($sformatf("line %0d ack,err", lineno), 32'({ack, err}),
                                  (op == "W") ? 32'd2 : 32'd1);
                    if (op == "W" && adr[31:28] == 4'h2) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) begin
                                led_model[8*b +: 8] = dat[8*b +: 8];
                            end
                        end
                    end
                    compare_value("led", 32'(led), 32'(led_model[7:0]));
                end
                "R", "Q": begin
                    bus_access(m[0], 1'b0, adr, '0, sel, ack, err, rdat);
                    compare_value($sformatf("line %0d ack,err", lineno), 32'({ack, err}),
                                  (op == "R") ? 32'd2 : 32'd1);
                    if (op == "R") begin
                        compare_value($sformatf("line %0d read data", lineno), rdat, exp_val);
                    end
                end
                "C": begin
                    c_adr[m[0]] = adr;
                    c_exp[m[0]] = exp_val;
                    if (m[0]) begin  // second line of the pair starts both
                        contend_read(c_adr[0], c_adr[1], c_exp[0], c_exp[1]);
                    end
                end
                "B": press_button(m[0], exp_val[3:0]);
                default: begin
                    failures++;
                    $display("unknown operation on stimulus line %0d", lineno);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== tests/wb_soc_stimulus.txt ====
# op master address data sel expected, all hex except master
# W write, R read, E write ending in err, Q read ending in err, C paired read, B button (master = button, expected = led4)
W 0 00000010 11223344 f 00000000
W 1 00000014 a5a5a5a5 f 00000000
W 0 00000010 0000bb00 2 00000000
W 1 00000014 cc000000 8 00000000
R 0 00000010 00000000 f 1122bb44
R 1 00000014 00000000 f cca5a5a5
R 0 00000410 00000000 f 1122bb44
W 0 0fff0014 deadbeef 3 00000000
R 1 00000014 00000000 f cca5beef
W 0 20000000 87654321 f 00000000
W 1 20000004 000000c3 1 00000000
R 0 20000008 00000000 f 876543c3
E 0 10000010 ffffffff f 00000000
E 1 30000000 ffffffff f 00000000
Q 0 f0000014 00000000 f 00000000
R 1 00000010 00000000 f 1122bb44
R 0 20000000 00000000 f 876543c3
C 0 00000010 00000000 f 1122bb44
C 1 00000014 00000000 f cca5beef
B 0 00000000 00000000 0 00000001
B 0 00000000 00000000 0 00000002
B 0 00000000 00000000 0 00000003
B 0 00000000 00000000 0 00000004
B 0 00000000 00000000 0 00000005
B 0 00000000 00000000 0 00000006
B 0 00000000 00000000 0 00000007
B 0 00000000 00000000 0 00000000
B 1 00000000 00000000 0 00000007

// ==== verilog/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // address map, 16 regions of 256 MB each
    localparam int REGION_LSB = 28;
    localparam logic [ADDR_W-REGION_LSB-1:0] REGION_RAM = 4'h0;  // stands in for ddr
    localparam logic [ADDR_W-REGION_LSB-1:0] REGION_LED = 4'h2;

    // word ram, index taken from adr[9:2]
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    localparam int N_MASTERS = 2;

    // status display
    localparam int STATUS_ENTRIES = 8;
    localparam int STATUS_IDX_W   = $clog2(STATUS_ENTRIES);

    // entries 4..7, entry 4 is element 0
    localparam logic [3:0][7:0] STATUS_PATTERNS = {
        8'h0F,
        8'hF0,
        8'h55,
        8'hAA
    };

    // master to slave, wishbone classic
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;  // valid with ack on reads
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/status_display.sv ====
`default_nettype none

module status_display (
    input  wire logic        sys_clk,
    input  wire logic        rst,
    input  wire logic        btn_up,
    input  wire logic        btn_down,
    input  wire logic [31:0] led_reg,
    output logic [7:0]       led8,
    output logic [3:0]       led4
);
    import soc_pkg::*;

    logic [1:0]              btn_q;   // {down, up}
    logic [1:0]              btn_qq;
    logic [1:0]              rise;
    logic [STATUS_IDX_W-1:0] idx;
    logic [7:0]              entry [STATUS_ENTRIES];

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            btn_q  <= '0;
            btn_qq <= '0;
        end else begin
            btn_q  <= {btn_down, btn_up};
            btn_qq <= btn_q;
        end
    end

    assign rise = btn_q & ~btn_qq;

    // wraps both ways, both buttons at once cancel
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            idx <= '0;
        end else if (rise[0] && !rise[1]) begin
            idx <= idx + STATUS_IDX_W'(1);
        end else if (rise[1] && !rise[0]) begin
            idx <= idx - STATUS_IDX_W'(1);
        end
    end

    // low half is the led register, high half fixed patterns
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            entry[i]     = led_reg[8*i +: 8];
            entry[i + 4] = STATUS_PATTERNS[i];
        end
    end

    assign led8 = ~entry[idx];  // leds are active low
    assign led4 = 4'(idx);

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter (
    input  wire logic             sys_clk,
    input  wire logic             rst,
    input  wire soc_pkg::wb_req_t m0_req,
    input  wire soc_pkg::wb_req_t m1_req,
    output soc_pkg::wb_rsp_t      m0_rsp,
    output soc_pkg::wb_rsp_t      m1_rsp,
    output soc_pkg::wb_req_t      bus_req,
    input  wire soc_pkg::wb_rsp_t bus_rsp
);
    import soc_pkg::*;

    logic [N_MASTERS-1:0] gnt;        // one-hot, zero when idle
    logic                 last_owner; // index of the master that held the bus last
    logic [N_MASTERS-1:0] cyc_vec;
    logic                 owner_cyc;

    assign cyc_vec   = {m1_req.cyc, m0_req.cyc};
    assign owner_cyc = |(gnt & cyc_vec);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            gnt        <= '0;
            last_owner <= 1'b1;  // so m0 wins the first tie
        end else if (gnt == '0) begin
            if (cyc_vec[0] && (!cyc_vec[1] || last_owner)) begin
                gnt <= 2'b01;
            end else if (cyc_vec[1]) begin
                gnt <= 2'b10;
            end
        end else if (!owner_cyc) begin
            // owner dropped cyc, free the bus
            gnt        <= '0;
            last_owner <= gnt[1];
        end
    end

    // forward the owner's request, nothing when idle
    always_comb begin
        if (gnt[1]) begin
            bus_req = m1_req;
        end else begin
            bus_req = m0_req;
        end
        if (gnt == '0) begin
            bus_req.cyc = 1'b0;
            bus_req.stb = 1'b0;
        end
    end

    // response only to the owner
    always_comb begin
        m0_rsp = '0;
        m1_rsp = '0;
        if (gnt[0]) begin
            m0_rsp = bus_rsp;
        end
        if (gnt[1]) begin
            m1_rsp = bus_rsp;
        end
    end

    a_gnt_onehot: assert property (
        @(posedge sys_clk) disable iff (rst)
        $onehot0(gnt)
    );

    // no handover in the middle of a cycle
    a_gnt_held: assert property (
        @(posedge sys_clk) disable iff (rst)
        owner_cyc |=> $stable(gnt)
    );

endmodule

`default_nettype wire

// ==== verilog/wb_decoder.sv ====
`default_nettype none

module wb_decoder (
    input  wire logic             sys_clk,
    input  wire logic             rst,
    input  wire soc_pkg::wb_req_t bus_req,
    output soc_pkg::wb_rsp_t      bus_rsp,
    output soc_pkg::wb_req_t      ram_req,
    output soc_pkg::wb_req_t      led_req,
    input  wire soc_pkg::wb_rsp_t ram_rsp,
    input  wire soc_pkg::wb_rsp_t led_rsp
);
    import soc_pkg::*;

    logic [ADDR_W-REGION_LSB-1:0] region;
    logic                         hit_ram;
    logic                         hit_led;
    logic                         err_q;

    assign region  = bus_req.adr[ADDR_W-1:REGION_LSB];
    assign hit_ram = (region == REGION_RAM);
    assign hit_led = (region == REGION_LED);

    // strobe only reaches the addressed slave
    always_comb begin
        ram_req     = bus_req;
        led_req     = bus_req;
        ram_req.stb = bus_req.stb & hit_ram;
        led_req.stb = bus_req.stb & hit_led;
    end

    // unmapped regions end with err, same timing as a slave ack
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= bus_req.cyc & bus_req.stb & ~hit_ram & ~hit_led & ~err_q;
        end
    end

    always_comb begin
        bus_rsp.ack = ram_rsp.ack | led_rsp.ack;
        bus_rsp.err = err_q | ram_rsp.err | led_rsp.err;
        if (ram_rsp.ack) begin
            bus_rsp.dat = ram_rsp.dat;
        end else if (led_rsp.ack) begin
            bus_rsp.dat = led_rsp.dat;
        end else begin
            bus_rsp.dat = '0;  // err carries no data
        end
    end

    a_ack_err_excl: assert property (
        @(posedge sys_clk) disable iff (rst)
        !(bus_rsp.ack && bus_rsp.err)
    );

endmodule

`default_nettype wire

// ==== verilog/wb_led_slave.sv ====
`default_nettype none

module wb_led_slave (
    input  wire logic             sys_clk,
    input  wire logic             rst,
    input  wire soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t      rsp,
    output logic [31:0]           led_reg
);
    import soc_pkg::*;

    logic take;
    logic ack_q;

    // same register at every offset in the region
    assign take = req.cyc & req.stb & ~ack_q;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            led_reg <= '0;
        end else if (take && req.we) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (req.sel[b]) begin
                    led_reg[8*b +: 8] <= req.dat[8*b +: 8];
                end
            end
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.err = 1'b0;
    assign rsp.dat = led_reg;  // stable across the read, no capture needed

endmodule

`default_nettype wire

// ==== verilog/wb_ram_slave.sv ====
`default_nettype none

module wb_ram_slave (
    input  wire logic             sys_clk,
    input  wire logic             rst,
    input  wire soc_pkg::wb_req_t req,
    output soc_pkg::wb_rsp_t      rsp
);
    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;
    logic              take;   // first cycle of a transfer
    logic              ack_q;
    logic [DATA_W-1:0] dat_q;

    // word index, offset bits above 9 alias
    assign idx  = req.adr[RAM_AW+1:2];
    assign take = req.cyc & req.stb & ~ack_q;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    // byte merge on write
    always_ff @(posedge sys_clk) begin
        if (take && req.we) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (req.sel[b]) begin
                    mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            dat_q <= mem[idx];  // old word on a write, ignored by the master
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.err = 1'b0;
    assign rsp.dat = dat_q;

    // one response per transfer even with stb held
    a_ack_single: assert property (
        @(posedge sys_clk) disable iff (rst)
        rsp.ack |=> !rsp.ack
    );

endmodule

`default_nettype wire

// ==== verilog/wb_soc_top.sv ====
`default_nettype none

module wb_soc_top (
    input  wire logic             sys_clk,
    input  wire logic             rst,
    input  wire soc_pkg::wb_req_t m0_req,
    input  wire soc_pkg::wb_req_t m1_req,
    output soc_pkg::wb_rsp_t      m0_rsp,
    output soc_pkg::wb_rsp_t      m1_rsp,
    input  wire logic [1:0]       btn,    // 0 up, 1 down
    output logic [7:0]            led,
    output logic [7:0]            led8,
    output logic [3:0]            led4
);
    import soc_pkg::*;

    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    wb_req_t     ram_req;
    wb_rsp_t     ram_rsp;
    wb_req_t     led_req;
    wb_rsp_t     led_rsp;
    logic [31:0] led_reg;

    wb_arbiter u_arbiter (
        .sys_clk (sys_clk),
        .rst     (rst),
        .m0_req  (m0_req),
        .m1_req  (m1_req),
        .m0_rsp  (m0_rsp),
        .m1_rsp  (m1_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    wb_decoder u_decoder (
        .sys_clk (sys_clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .ram_req (ram_req),
        .led_req (led_req),
        .ram_rsp (ram_rsp),
        .led_rsp (led_rsp)
    );

    // region 0
    wb_ram_slave u_ram (
        .sys_clk (sys_clk),
        .rst     (rst),
        .req     (ram_req),
        .rsp     (ram_rsp)
    );

    // region 2
    wb_led_slave u_led (
        .sys_clk (sys_clk),
        .rst     (rst),
        .req     (led_req),
        .rsp     (led_rsp),
        .led_reg (led_reg)
    );

    status_display u_status (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .btn_up   (btn[0]),
        .btn_down (btn[1]),
        .led_reg  (led_reg),
        .led8     (led8),
        .led4     (led4)
    );

    assign led = led_reg[7:0];

endmodule

`default_nettype wire

// ==== wb_soc_top.f ====
verilog/soc_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_decoder.sv
verilog/wb_ram_slave.sv
verilog/wb_led_slave.sv
verilog/status_display.sv
verilog/wb_soc_top.sv
tests/tb_wb_soc_top.sv
